// ==== Makefile ====
# Verilator flow for the IVMU testbench

TOP := tb_ivmu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

# Pass only if the simulation printed the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f
	verilator --lint-only --assert --top-module ivmu_top \
		src/ivmu_irq_pkg.sv src/ivmu_regmap_pkg.sv \
		src/ivmu_irq_arbiter.sv src/ivmu_regfile.sv src/ivmu_top.sv

clean:
	rm -rf obj_dir

// ==== sim/tb_ivmu_ref.svh ====
// IVMU reference model
`ifndef TB_IVMU_REF_SVH
`define TB_IVMU_REF_SVH

// Start state of the random sequence
localparam logic [31:0] LFSR_SEED = 32'h2e39_a830;

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// Vector of the highest unmasked active source, zero if none
function automatic vector_t ref_vector(
    input irq_mask_t srcs,
    input irq_mask_t msk,
    input vector_t   tbl [NUM_IRQ]
);
    irq_mask_t live;
    vector_t   result;
    logic      found;
    live   = srcs & ~msk;
    result = '0;
    found  = 1'b0;
    // Walk down from the top source, first hit wins
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
        if (live[i] && !found) begin
            result = tbl[i];
            found  = 1'b1;
        end
    end
    return result;
endfunction

// Expected read data for one address
function automatic reg_data_t ref_read(
    input reg_addr_t a,
    input vector_t   tbl [NUM_IRQ],
    input reg_data_t mask_word,
    input irq_mask_t srcs
);
    reg_data_t result;
    result = '0;
    if (a < reg_addr_t'(NUM_IRQ)) begin
        result = tbl[a[IRQ_IDX_W-1:0]];
    end else if (a == MASK_ADDR) begin
        result = mask_word;
    end else if (a == STATUS_ADDR) begin
        // Only the low mask bits gate sources
        result = reg_data_t'(srcs & ~mask_word[NUM_IRQ-1:0]);
    end
    return result;
endfunction

`endif

// ==== sim/tb_ivmu.sv ====
// IVMU testbench
`timescale 1ns/1ps

module tb_ivmu
    import ivmu_irq_pkg::*, ivmu_regmap_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;

    // Test lengths
    localparam int N_UNMAPPED    = 8;
    localparam int N_IRQ_ITER    = 24;
    localparam int N_STATUS_ITER = 8;
    localparam int N_BP_ITER     = 4;

    // Scheduled operations, each given 20 cycles
    localparam int NUM_OPS = 3 * NUM_REGS + (NUM_IRQ + 1) + 2 + 2 * N_UNMAPPED
                           + 2 * N_IRQ_ITER + N_STATUS_ITER + 2 * N_BP_ITER;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * NUM_OPS;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              wr_valid;
    logic              rd_valid;
    logic              rdata_ready;
    logic [DATA_W-1:0] rdata;
    logic              rdata_valid;
    irq_mask_t         irq_sources;
    logic [VEC_W-1:0]  irq_vector;
    logic              irq_valid;

    // Shadow copy of the register map
    vector_t   shadow_vec [NUM_IRQ];
    reg_data_t shadow_mask;

    // Expected read data in issue order
    reg_data_t exp_q [$];
    reg_data_t popped;

    logic [31:0] lfsr_q;

    `include "tb_ivmu_ref.svh"

    ivmu_top ivmu_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (addr),
        .wdata       (wdata),
        .wr_valid    (wr_valid),
        .rd_valid    (rd_valid),
        .rdata_ready (rdata_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .irq_sources (irq_sources),
        .irq_vector  (irq_vector),
        .irq_valid   (irq_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // One LFSR step per bit taken, MSB first
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with_failure($sformatf("** Error: %s = 0x%08h, expected 0x%08h",
                                    name, got, exp));
    endtask

    // Next drive point, 1 ns past the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        addr     = a;
        wdata    = d;
        wr_valid = 1'b1;
        // Status and unmapped writes leave the shadow alone
        if (a < reg_addr_t'(NUM_IRQ)) begin
            shadow_vec[a[IRQ_IDX_W-1:0]] = d;
        end else if (a == MASK_ADDR) begin
            shadow_mask = d;
        end
        tick();
        wr_valid = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a);
        exp_q.push_back(ref_read(a, shadow_vec, shadow_mask, irq_sources));
        addr     = a;
        rd_valid = 1'b1;
        tick();
        rd_valid = 1'b0;
    endtask

    task automatic readback_all();
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(reg_addr_t'(i));
        end
    endtask

    // Wait until every issued read has been checked
    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        tick();
    endtask

    // Outputs one edge after the sources changed
    task automatic check_irq();
        logic    exp_valid;
        vector_t exp_vector;
        @(posedge clk);
        @(negedge clk);
        exp_valid  = |(irq_sources & ~shadow_mask[NUM_IRQ-1:0]);
        exp_vector = ref_vector(irq_sources, shadow_mask[NUM_IRQ-1:0], shadow_vec);
        assert (irq_valid == exp_valid)
            else report_mismatch("irq_valid", 32'(irq_valid), 32'(exp_valid));
        assert (irq_vector == exp_vector)
            else report_mismatch("irq_vector", irq_vector, exp_vector);
        tick();
    endtask

    // Response held under back-pressure, then replaced by a second read
    task automatic run_backpressure();
        reg_addr_t addr_a;
        reg_data_t exp_a;
        int        hold;
        rdata_ready = 1'b0;
        addr_a      = reg_addr_t'(rand_bits(5) % (NUM_IRQ + 1));
        exp_a       = ref_read(addr_a, shadow_vec, shadow_mask, irq_sources);
        addr        = addr_a;
        rd_valid    = 1'b1;
        tick();
        rd_valid = 1'b0;
        // Response lands on this edge
        tick();
        hold = 2 + int'(rand_bits(3));
        repeat (hold) begin
            @(negedge clk);
            assert (rdata_valid == 1'b1)
                else report_mismatch("rdata_valid", 32'(rdata_valid), 32'h1);
            assert (rdata == exp_a) else report_mismatch("rdata", rdata, exp_a);
            tick();
        end
        read_reg(reg_addr_t'(rand_bits(5) % (NUM_IRQ + 1)));
        tick();
        rdata_ready = 1'b1;
        wait_idle();
    endtask

    // Compare process, one pop per consumed response
    always @(negedge clk) begin
        if (rst_n && rdata_valid && rdata_ready) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("Read response arrived with no read outstanding");
            end else begin
                popped = exp_q.pop_front();
                assert (rdata == popped) else report_mismatch("rdata", rdata, popped);
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_with_failure($sformatf("Timeout after %0d cycles, test did not finish",
                                    TIMEOUT_CYCLES));
    end

    initial begin
        rst_n       = 1'b0;
        addr        = '0;
        wdata       = '0;
        wr_valid    = 1'b0;
        rd_valid    = 1'b0;
        rdata_ready = 1'b1;
        irq_sources = '0;
        shadow_mask = '0;
        lfsr_q      = LFSR_SEED;
        for (int i = 0; i < NUM_IRQ; i++) begin
            shadow_vec[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state
        assert (rdata_valid == 1'b0)
            else report_mismatch("rdata_valid", 32'(rdata_valid), 32'h0);
        assert (irq_valid == 1'b0)
            else report_mismatch("irq_valid", 32'(irq_valid), 32'h0);
        readback_all();
        wait_idle();

        // Full table and mask, then readback
        for (int i = 0; i < NUM_IRQ; i++) begin
            write_reg(reg_addr_t'(i), rand_bits(32));
        end
        write_reg(MASK_ADDR, rand_bits(32));
        readback_all();
        write_reg(STATUS_ADDR, rand_bits(32));
        read_reg(STATUS_ADDR);
        // Unmapped space reads zero and must not alias onto the table
        for (int i = 0; i < N_UNMAPPED; i++) begin
            addr = reg_addr_t'(NUM_REGS + rand_bits(8) % (2 ** ADDR_W - NUM_REGS));
            write_reg(addr, rand_bits(32));
            read_reg(addr);
        end
        readback_all();
        wait_idle();

        // Priority select, every fourth pattern unmasked
        for (int i = 0; i < N_IRQ_ITER; i++) begin
            write_reg(MASK_ADDR, (i % 4 == 0) ? '0 : rand_bits(32));
            tick();
            tick();
            irq_sources = irq_mask_t'(rand_bits(NUM_IRQ));
            check_irq();
        end

        // Status with steady sources
        for (int i = 0; i < N_STATUS_ITER; i++) begin
            irq_sources = irq_mask_t'(rand_bits(NUM_IRQ));
            tick();
            tick();
            read_reg(STATUS_ADDR);
        end
        wait_idle();

        for (int i = 0; i < N_BP_ITER; i++) begin
            run_backpressure();
        end

        wait_idle();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== src/ivmu_irq_arbiter.sv ====
// IVMU interrupt arbiter
`timescale 1ns/1ps

module ivmu_irq_arbiter
    import ivmu_irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // Raw level sources
    input  irq_mask_t irq_sources,
    // Table and mask from the register file
    input  vector_t   vectors [NUM_IRQ],
    input  irq_mask_t mask,
    // Masked sources, also stored as status
    output irq_mask_t pending,
    // Registered interrupt output
    output vector_t   irq_vector,
    output logic      irq_valid
);

    // Winning source and whether there is one
    irq_idx_t win_idx;
    logic     win_found;
    vector_t  win_vector;

    // Set mask bit blocks the source
    assign pending = irq_sources & ~mask;

    // Highest-numbered pending source wins
    // Ascending scan, later hits overwrite earlier ones
    always_comb begin
        win_idx   = '0;
        win_found = 1'b0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (pending[i]) begin
                win_idx   = irq_idx_t'(i);
                win_found = 1'b1;
            end
        end
    end

    // Vector of the winner, zero when idle
    assign win_vector = win_found ? vectors[win_idx] : '0;

    // Outputs lag sources, mask and table by one edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_vector <= '0;
            irq_valid  <= 1'b0;
        end else begin
            irq_vector <= win_vector;
            irq_valid  <= |pending;
        end
    end

    // Idle output carries no stale vector
    a_idle_vector_zero : assert property (
        @(posedge clk) disable iff (!rst_n)
        !irq_valid |-> irq_vector == '0
    ) else $error("irq_vector nonzero while irq_valid low");

endmodule

// ==== src/ivmu_irq_pkg.sv ====
// Interrupt side definitions
package ivmu_irq_pkg;

    // Number of level-sensitive interrupt sources
    localparam int NUM_IRQ = 16;

    // Width of one vector table entry
    localparam int VEC_W = 32;

    // Bits needed to number a source
    localparam int IRQ_IDX_W = $clog2(NUM_IRQ);

    // One bit per source, used for sources, mask and pending
    typedef logic [NUM_IRQ-1:0] irq_mask_t;

    // Source number, also the vector table index
    typedef logic [IRQ_IDX_W-1:0] irq_idx_t;

    // One vector table entry
    typedef logic [VEC_W-1:0] vector_t;

endpackage

// ==== src/ivmu_regfile.sv ====
// IVMU register file
`timescale 1ns/1ps

module ivmu_regfile
    import ivmu_irq_pkg::*, ivmu_regmap_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Software port
    input  reg_addr_t  addr,
    input  reg_data_t  wdata,
    input  logic       wr_valid,
    input  logic       rd_valid,
    input  logic       rdata_ready,
    output reg_data_t  rdata,
    output logic       rdata_valid,
    // To the arbiter
    output vector_t    vectors [NUM_IRQ],
    output irq_mask_t  mask,
    // Masked sources from the arbiter
    input  irq_mask_t  pending
);

    // Register storage
    vector_t   vectors_q [NUM_IRQ];
    reg_data_t mask_q;
    irq_mask_t status_q;

    // Address decode
    logic      addr_mapped;
    logic      addr_is_vec;
    irq_idx_t  vec_idx;

    // Read path
    reg_data_t rd_mux;
    logic      req_valid;
    reg_data_t req_data;

    // Only addresses below NUM_REGS are decoded at all
    assign addr_mapped = (addr < reg_addr_t'(NUM_REGS));
    assign addr_is_vec = (addr < reg_addr_t'(NUM_IRQ));

    // Low address bits select the table entry
    assign vec_idx = irq_idx_t'(addr);

    // Table and mask go straight to the arbiter
    assign vectors = vectors_q;

    // Only the low bits of the mask word reach the sources
    assign mask = mask_q[NUM_IRQ-1:0];

    // Write port
    // Status and unmapped addresses drop the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_IRQ; i++) begin
                vectors_q[i] <= '0;
            end
            mask_q <= '0;
        end else if (wr_valid && addr_mapped) begin
            if (addr_is_vec) begin
                vectors_q[vec_idx] <= wdata;
            end else if (addr == MASK_ADDR) begin
                // Full word kept so readback matches what was written
                mask_q <= wdata;
            end
        end
    end

    // Status follows pending on every edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= '0;
        end else begin
            status_q <= pending;
        end
    end

    // Read select, zero for anything unmapped
    always_comb begin
        rd_mux = '0;
        if (addr_mapped) begin
            if (addr_is_vec) begin
                rd_mux = vectors_q[vec_idx];
            end else if (addr == MASK_ADDR) begin
                rd_mux = mask_q;
            end else if (addr == STATUS_ADDR) begin
                // Status zero-extended to the data width
                rd_mux = reg_data_t'(status_q);
            end
        end
    end

    // Request stage
    // Registers are sampled at the accepting edge, so a same-cycle
    // write to the same address is not seen by this read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            req_data <= rd_mux;
        end
    end

    // Output stage
    // A new response always wins, even over one being consumed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata       <= '0;
            rdata_valid <= 1'b0;
        end else if (req_valid) begin
            rdata       <= req_data;
            rdata_valid <= 1'b1;
        end else if (rdata_valid && rdata_ready) begin
            // Consumed, data left as is
            rdata_valid <= 1'b0;
        end
    end

    // Held response must not move unless replaced
    a_rdata_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        rdata_valid && !rdata_ready && !req_valid |=> rdata_valid && $stable(rdata)
    ) else $error("rdata changed while held under back-pressure");

    // Handshake flag never goes unknown out of reset
    a_rdata_valid_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(rdata_valid)
    ) else $error("rdata_valid is unknown");

endmodule

// ==== src/ivmu_regmap_pkg.sv ====
// Register map definitions
package ivmu_regmap_pkg;

    // Software port widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // Register address and data words
    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] reg_data_t;

    // Vector table sits at 0 to 15, directly indexed by source number

    // Mask register, set bit blocks the source
    localparam reg_addr_t MASK_ADDR = 8'd16;

    // Read-only status, masked pending sources
    localparam reg_addr_t STATUS_ADDR = 8'd17;

    // Count of mapped registers
    // Everything at or above this reads as zero and drops writes
    localparam int NUM_REGS = 18;

endpackage

// ==== src/ivmu_top.sv ====
// IVMU top level
`timescale 1ns/1ps

module ivmu_top
    import ivmu_irq_pkg::*, ivmu_regmap_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Register port, plain strobes
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              wr_valid,
    input  logic              rd_valid,
    input  logic              rdata_ready,
    // Read response
    output logic [DATA_W-1:0] rdata,
    output logic              rdata_valid,
    // Interrupt side
    input  logic [NUM_IRQ-1:0] irq_sources,
    output logic [VEC_W-1:0]  irq_vector,
    output logic              irq_valid
);

    // Table and mask into the arbiter
    vector_t   vectors [NUM_IRQ];
    irq_mask_t mask;

    // Masked sources back to status
    irq_mask_t pending;

    // Registers and read path
    ivmu_regfile ivmu_regfile_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (addr),
        .wdata       (wdata),
        .wr_valid    (wr_valid),
        .rd_valid    (rd_valid),
        .rdata_ready (rdata_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .vectors     (vectors),
        .mask        (mask),
        .pending     (pending)
    );

    // Masking and priority select
    ivmu_irq_arbiter ivmu_irq_arbiter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_sources (irq_sources),
        .vectors     (vectors),
        .mask        (mask),
        .pending     (pending),
        .irq_vector  (irq_vector),
        .irq_valid   (irq_valid)
    );

endmodule

// ==== verilog.f ====
+incdir+sim
src/ivmu_irq_pkg.sv
src/ivmu_regmap_pkg.sv
src/ivmu_irq_arbiter.sv
src/ivmu_regfile.sv
src/ivmu_top.sv
sim/tb_ivmu.sv
